// ==== Makefile ====
# Verilator build and run of the CSR unit testbench

SIM := obj_dir/Vcsr_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): csr_unit.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f csr_unit.f \
		--top-module csr_tb -Mdir obj_dir

# The log decides pass or fail
run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/csr_tb.sv ====
// Testbench for the machine-mode CSR unit
// Drives Zicsr instructions, traps, counter events and interrupt lines into csr_top
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb import csr_arch_pkg::*;;

    // Budget of 40 cycles for each CSR instruction or trap
    localparam int max_ops = 60;

    logic        clk = 1'b0;
    logic        rstz;
    csr_word_t   ir, wr_data, trapped_pc, trap_cause, trap_value;
    logic        csr_start, activate_trap, return_trap, instret;
    logic        irq_software, irq_timer, irq_external;
    csr_word_t   rd_data, trap_addr;
    logic [4:0]  csr_rd;
    logic        csr_write, done, trap_jump, irq_pending;

    int          errors = 0;
    int          ops = 0;
    logic [15:0] lfsr_q = 16'd53;
    // Expected CSR contents by address, absent until known
    csr_word_t   ref_csr [logic [11:0]];

    csr_top i_dut (.*);

    always #4 clk = ~clk;

    // ======================================================================
    // Reporting and stimulus helpers

    task automatic mismatch(input string name, input csr_word_t got, input csr_word_t exp);
        errors++;
        $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%s at %0t ns", what, $time);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output csr_word_t w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[i]   = lfsr_q[15];
        end
    endtask

    // Zicsr modify rules
    function automatic csr_word_t apply_op(input logic [1:0] f3, input csr_word_t old_v,
                                           input csr_word_t d);
        case (f3)
            CSR_RS:  return old_v | d;
            CSR_RC:  return old_v & ~d;
            default: return d;
        endcase
    endfunction

    // Writable fields only; mpp pinned to machine, mtvec and mepc word aligned
    function automatic csr_word_t legalize(input logic [11:0] a, input csr_word_t v);
        case (a)
            MSTATUS:     return (v & 32'h0000_0088) | 32'h0000_1800;
            MIE:         return v & 32'h0000_0888;
            MTVEC, MEPC: return {v[31:2], 2'b00};
            default:     return v;
        endcase
    endfunction

    task automatic run_csr(input logic [1:0] f3, input logic [11:0] a, input logic [4:0] rs1,
                           input logic [4:0] rd, input csr_word_t d, output csr_word_t got);
        int waited;
        @(negedge clk);
        ir        = {a, rs1, 1'b0, f3, rd, 7'b1110011};
        wr_data   = d;
        csr_start = 1'b1;
        @(negedge clk);
        csr_start = 1'b0;
        waited    = 0;
        // READ stretches while a counter carry settles
        while (!done && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        ops++;
        if (!done) note_failure("CSR instruction never raised done");
        assert (csr_write === (rd != 5'd0))
            else mismatch("csr_write", 32'(csr_write), 32'(rd != 5'd0));
        assert (csr_rd === rd) else mismatch("csr_rd", 32'(csr_rd), 32'(rd));
        got = rd_data;
    endtask

    task automatic check_csr(input logic [1:0] f3, input logic [11:0] a, input logic [4:0] rs1,
                             input logic [4:0] rd, input csr_word_t d);
        csr_word_t got;
        csr_word_t old_v;
        logic      known;
        known = (ref_csr.exists(a) != 0);
        old_v = '0;
        if (known) old_v = ref_csr[a];
        run_csr(f3, a, rs1, rd, d, got);
        if (known) begin
            assert (got === old_v) else mismatch("rd_data", got, old_v);
        end
        // RS and RC with rs1 zero only read
        if (f3 == CSR_RW || rs1 != 5'd0) ref_csr[a] = legalize(a, apply_op(f3, old_v, d));
    endtask

    task automatic enter_trap(input csr_word_t pc, input csr_word_t cause, input csr_word_t val);
        csr_word_t st;
        @(negedge clk);
        trapped_pc    = pc;
        trap_cause    = cause;
        trap_value    = val;
        activate_trap = 1'b1;
        @(negedge clk);
        activate_trap = 1'b0;
        assert (trap_jump === 1'b1) else note_failure("Trap entry gave no trap_jump");
        assert (trap_addr === ref_csr[MTVEC]) else mismatch("trap_addr", trap_addr, ref_csr[MTVEC]);
        @(negedge clk);
        assert (trap_jump === 1'b0) else note_failure("trap_jump longer than one cycle");
        ops++;
        // mie stacked into mpie
        st               = ref_csr[MSTATUS];
        ref_csr[MSTATUS] = 32'h0000_1800 | (st[3] ? 32'h0000_0080 : 32'h0);
        ref_csr[MEPC]    = {pc[31:2], 2'b00};
        ref_csr[MCAUSE]  = cause;
        ref_csr[MTVAL]   = val;
    endtask

    task automatic leave_trap();
        csr_word_t st;
        @(negedge clk);
        return_trap = 1'b1;
        @(negedge clk);
        return_trap = 1'b0;
        assert (trap_jump === 1'b1) else note_failure("mret gave no trap_jump");
        assert (trap_addr === ref_csr[MEPC]) else mismatch("trap_addr", trap_addr, ref_csr[MEPC]);
        @(negedge clk);
        assert (trap_jump === 1'b0) else note_failure("trap_jump longer than one cycle");
        ops++;
        st               = ref_csr[MSTATUS];
        ref_csr[MSTATUS] = 32'h0000_1880 | (st[7] ? 32'h0000_0008 : 32'h0);
    endtask

    task automatic pulse_instret(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            instret = 1'b1;
            @(negedge clk);
            instret = 1'b0;
        end
    endtask

    // Strobes are single-cycle, writeback only with done
    a_done_pulse: assert property (@(posedge clk) disable iff (!rstz) done |=> !done)
        else note_failure("done held for more than one cycle");
    a_jump_pulse: assert property (@(posedge clk) disable iff (!rstz) trap_jump |=> !trap_jump)
        else note_failure("trap_jump held for more than one cycle");
    a_write_done: assert property (@(posedge clk) disable iff (!rstz) csr_write |-> done)
        else note_failure("csr_write raised outside done");

    initial begin
        #(max_ops * 40 * 8);
        $display("Watchdog expired after %0d cycles, the run is stuck", max_ops * 40);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ======================================================================
    // Test sequence

    initial begin
        csr_word_t v;
        csr_word_t hi;
        csr_word_t got;
        csr_word_t first;
        int        n;
        int        waited;
        rstz          = 1'b0;
        ir            = '0;
        wr_data       = '0;
        trapped_pc    = '0;
        trap_cause    = '0;
        trap_value    = '0;
        csr_start     = 1'b0;
        activate_trap = 1'b0;
        return_trap   = 1'b0;
        instret       = 1'b0;
        irq_software  = 1'b0;
        irq_timer     = 1'b0;
        irq_external  = 1'b0;
        ref_csr[MSTATUS] = 32'h0000_1800;
        ref_csr[MTVEC]   = `CSR_BOOT_ADDR;
        ref_csr[MIE]     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstz = 1'b1;

        // Reset values
        assert (!done && !trap_jump && !irq_pending) else note_failure("Strobe high after reset");
        check_csr(CSR_RS, MSTATUS, 5'd0, 5'd1, '0);
        check_csr(CSR_RS, MTVEC, 5'd0, 5'd2, '0);

        // RW, RS, RC; first pass writes back to x0
        for (int i = 0; i < 4; i++) begin
            take_bits(32, v);
            check_csr(CSR_RW, MSCRATCH, 5'd5, 5'(i), v);
            take_bits(32, v);
            check_csr(CSR_RS, MSCRATCH, 5'd6, 5'd7, v);
            take_bits(32, v);
            check_csr(CSR_RC, MSCRATCH, 5'd8, 5'd9, v);
            take_bits(32, v);
            check_csr(CSR_RW, MTVEC, 5'd10, 5'd11, v);
            take_bits(32, v);
            check_csr(CSR_RS, MTVEC, 5'd12, 5'(i), v);
            take_bits(32, v);
            check_csr(CSR_RC, MTVEC, 5'd13, 5'd14, v);
        end
        // rs1 zero keeps the register
        check_csr(CSR_RS, MSCRATCH, 5'd0, 5'd3, 32'hFFFF_FFFF);
        check_csr(CSR_RC, MTVEC, 5'd0, 5'd3, 32'hFFFF_FFFF);
        check_csr(CSR_RS, MSCRATCH, 5'd0, 5'd3, '0);
        check_csr(CSR_RS, MTVEC, 5'd0, 5'd3, '0);

        // Trap entry with mie set, then mret
        check_csr(CSR_RS, MSTATUS, 5'd1, 5'd0, 32'h0000_0008);
        take_bits(32, v);
        take_bits(32, hi);
        take_bits(32, first);
        enter_trap(v, hi, first);
        check_csr(CSR_RS, MEPC, 5'd0, 5'd4, '0);
        check_csr(CSR_RS, MCAUSE, 5'd0, 5'd4, '0);
        check_csr(CSR_RS, MTVAL, 5'd0, 5'd4, '0);
        check_csr(CSR_RS, MSTATUS, 5'd0, 5'd4, '0);
        leave_trap();
        check_csr(CSR_RS, MSTATUS, 5'd0, 5'd4, '0);

        // minstret plus N pulses
        take_bits(32, v);
        run_csr(CSR_RW, MINSTRET, 5'd1, 5'd0, v, got);
        take_bits(3, hi);
        n = int'(hi[2:0]) + 1;
        pulse_instret(n);
        run_csr(CSR_RS, MINSTRET, 5'd0, 5'd3, '0, got);
        assert (got === v + csr_word_t'(n)) else mismatch("minstret", got, v + csr_word_t'(n));
        // Low half wrap carries into the high half
        take_bits(32, hi);
        run_csr(CSR_RW, MINSTRETH, 5'd1, 5'd0, hi, got);
        run_csr(CSR_RW, MINSTRET, 5'd1, 5'd0, 32'hFFFF_FFFF, got);
        pulse_instret(1);
        run_csr(CSR_RS, MINSTRETH, 5'd0, 5'd3, '0, got);
        assert (got === hi + 32'd1) else mismatch("minstreth", got, hi + 32'd1);
        run_csr(CSR_RS, MINSTRET, 5'd0, 5'd3, '0, got);
        assert (got === 32'd0) else mismatch("minstret", got, 32'd0);
        // mcycle runs freely, mcycleh is writable
        run_csr(CSR_RS, MCYCLE, 5'd0, 5'd3, '0, first);
        run_csr(CSR_RS, MCYCLE, 5'd0, 5'd3, '0, got);
        assert (got > first) else note_failure("mcycle did not advance between two reads");
        take_bits(32, hi);
        run_csr(CSR_RW, MCYCLEH, 5'd1, 5'd0, hi, got);
        run_csr(CSR_RS, MCYCLEH, 5'd0, 5'd3, '0, got);
        assert (got === hi) else mismatch("mcycleh", got, hi);

        // Timer interrupt, enabled and then masked globally
        check_csr(CSR_RW, MIE, 5'd1, 5'd0, 32'h0000_0080);
        check_csr(CSR_RS, MSTATUS, 5'd1, 5'd0, 32'h0000_0008);
        @(negedge clk);
        irq_timer = 1'b1;
        waited    = 0;
        while (!irq_pending && waited < 3) begin
            @(negedge clk);
            waited++;
        end
        assert (irq_pending) else note_failure("irq_pending missing three cycles after irq_timer");
        run_csr(CSR_RS, MIP, 5'd0, 5'd3, '0, got);
        assert (got === 32'h0000_0080) else mismatch("mip", got, 32'h0000_0080);
        check_csr(CSR_RC, MSTATUS, 5'd1, 5'd0, 32'h0000_0008);
        @(negedge clk);
        assert (!irq_pending) else note_failure("irq_pending high with mstatus.mie clear");
        run_csr(CSR_RS, MIP, 5'd0, 5'd3, '0, got);
        assert (got === 32'h0000_0080) else mismatch("mip", got, 32'h0000_0080);
        irq_timer = 1'b0;
        repeat (3) @(negedge clk);

        $display("Summary: %0d CSR instructions and traps, %0d errors", ops, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
// Shared defines live beside the RTL
+incdir+verilog
// Packages before their users
verilog/csr_arch_pkg.sv
verilog/csr_ctrl_pkg.sv
// Leaf modules, then the top level
verilog/csr_counter64.sv
verilog/csr_irq_sync.sv
verilog/csr_file.sv
verilog/csr_top.sv
// Testbench
bench/csr_tb.sv

// ==== verilog/csr_arch_pkg.sv ====
// Architectural types of the machine-mode CSR unit
// Imported by the CSR file, the counters, the interrupt synchronizer and the top level
`include "csr_params.svh"

package csr_arch_pkg;

    // Data word, also carries instruction, PC, cause and trap value
    typedef logic [`CSR_XLEN-1:0] csr_word_t;

    // CSR address field, ir[31:20]
    typedef logic [11:0] csr_addr_t;

    // Interrupt triple, ordered {external, timer, software}
    typedef logic [2:0] irq_vec_t;

    // Supported machine-mode registers
    typedef enum logic [11:0] {
        MSTATUS   = 12'h300,
        MIE       = 12'h304,
        MTVEC     = 12'h305,
        MSCRATCH  = 12'h340,
        MEPC      = 12'h341,
        MCAUSE    = 12'h342,
        MTVAL     = 12'h343,
        MIP       = 12'h344,
        MCYCLE    = 12'hB00,
        MINSTRET  = 12'hB02,
        MCYCLEH   = 12'hB80,
        MINSTRETH = 12'hB82
    } csr_addr_e;

    // funct3[1:0]; funct3[2] only picks the immediate form in the core
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // Privilege levels, only machine mode is implemented
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_SUPER   = 2'b01,
        PRIV_MACHINE = 2'b11
    } priv_e;

endpackage

// ==== verilog/csr_counter64.sv ====
// 64-bit performance counter built from two 32-bit halves
// Used for mcycle and minstret, each half loadable from a CSR write
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_counter64
    import csr_arch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstz,
    input  logic                   incr,
    input  logic                   load_low,
    input  logic                   load_high,
    input  csr_word_t              load_data,
    output logic [`CSR_COUNT_W-1:0] count,
    output logic                   count_vld
);

    csr_word_t count_low;
    csr_word_t count_high;
    logic      carry;

    // Low half, carry out registered to break the 64-bit adder
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            count_low <= '0;
            carry     <= 1'b0;
        end else begin
            // Carry lives for a single cycle
            carry <= 1'b0;
            if (load_low) begin
                count_low <= load_data;
            end else if (incr) begin
                count_low <= count_low + 1'b1;
                carry     <= (count_low == '1);
            end
        end
    end

    // High half picks up the carry one cycle later
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            count_high <= '0;
        end else if (load_high) begin
            count_high <= load_data;
        end else if (carry) begin
            count_high <= count_high + 1'b1;
        end
    end

    assign count     = {count_high, count_low};
    // Halves disagree while the carry is in flight
    assign count_vld = !carry;

    // CSR file writes one half per instruction
    a_one_load: assert property (@(posedge clk) disable iff (!rstz)
        !(load_low && load_high));

endmodule

// ==== verilog/csr_ctrl_pkg.sv ====
// Implementation types of the CSR sequencer
// Imported by the CSR file and the top level
package csr_ctrl_pkg;

    // Destination register index in the core register file
    typedef logic [4:0] reg_idx_t;

    // Sequencer states
    // READ waits for both counters to settle before the value is latched
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2,
        TRAP  = 2'd3
    } csr_state_e;

endpackage

// ==== verilog/csr_file.sv ====
// Machine-mode CSR file with the Zicsr read-modify-write sequencer
// Also handles trap entry and mret, and drives the counter loads and interrupt enables
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_file
    import csr_arch_pkg::*;
    import csr_ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstz,
    // Instruction port
    input  csr_word_t               ir,
    input  csr_word_t               wr_data,
    input  logic                    csr_start,
    output csr_word_t               rd_data,
    output reg_idx_t                csr_rd,
    output logic                    csr_write,
    output logic                    done,
    // Trap port
    input  logic                    activate_trap,
    input  logic                    return_trap,
    input  csr_word_t               trapped_pc,
    input  csr_word_t               trap_cause,
    input  csr_word_t               trap_value,
    output csr_word_t               trap_addr,
    output logic                    trap_jump,
    // Counters
    output csr_word_t               load_data,
    output logic                    mcycle_load_low,
    output logic                    mcycle_load_high,
    output logic                    minstret_load_low,
    output logic                    minstret_load_high,
    input  logic [`CSR_COUNT_W-1:0] mcycle,
    input  logic [`CSR_COUNT_W-1:0] minstret,
    input  logic                    mcycle_vld,
    input  logic                    minstret_vld,
    // Interrupts
    output logic                    glb_ie,
    output logic                    msie,
    output logic                    mtie,
    output logic                    meie,
    input  logic [2:0]              mip
);

    csr_state_e state, state_n;

    // Captured instruction fields
    csr_op_e   op;
    csr_addr_t addr;
    csr_word_t wdata_q;
    logic      wr_ok;
    logic      rd_ok;

    logic      rd_vld, wr_en;
    logic      setup_trap, return_from_trap;
    csr_word_t csr_rdata, csr_wdata;

    // Machine registers
    logic      mstatus_mie, mstatus_mpie;
    irq_vec_t  mie_q;
    csr_word_t mtvec, mscratch, mepc, mcause, mtval;

    // ====================================================================
    // Sequencer

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                // Instruction wins over trap entry
                if (csr_start) begin
                    state_n = READ;
                end else if (activate_trap) begin
                    state_n = TRAP;
                end
            end
            READ:    state_n = rd_vld ? WRITE : READ;
            WRITE:   state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    // Decode on start
    always_ff @(posedge clk) begin
        if (state == IDLE && csr_start) begin
            op      <= csr_op_e'(ir[13:12]);
            addr    <= ir[31:20];
            csr_rd  <= ir[11:7];
            wdata_q <= wr_data;
            // RS and RC with rs1 zero only read
            wr_ok   <= !((ir[13:12] == CSR_RS || ir[13:12] == CSR_RC) && ir[19:15] == '0);
            // No writeback to x0
            rd_ok   <= (ir[11:7] != '0);
        end
    end

    // Counter halves must agree before the read
    assign rd_vld    = mcycle_vld && minstret_vld;
    assign wr_en     = (state == WRITE) && wr_ok;
    assign done      = (state == WRITE);
    assign csr_write = (state == WRITE) && rd_ok;

    // Old value, held for the modify and for the core
    always_ff @(posedge clk) begin
        if (state == READ && rd_vld) begin
            rd_data <= csr_rdata;
        end
    end

    // Traps only start from IDLE without a pending instruction
    assign setup_trap       = (state == IDLE) && !csr_start && activate_trap;
    assign return_from_trap = (state == IDLE) && !csr_start && !activate_trap && return_trap;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            trap_jump <= 1'b0;
        end else begin
            trap_jump <= setup_trap || return_from_trap;
        end
    end

    // Direct mode vector on entry, mepc on mret
    always_ff @(posedge clk) begin
        if (setup_trap) begin
            trap_addr <= mtvec;
        end else if (return_from_trap) begin
            trap_addr <= mepc;
        end
    end

    // ====================================================================
    // Read mux and modify

    always_comb begin
        csr_rdata = '0;
        case (addr)
            MSTATUS: begin
                csr_rdata[3]     = mstatus_mie;
                csr_rdata[7]     = mstatus_mpie;
                // mpp fixed at machine mode
                csr_rdata[12:11] = PRIV_MACHINE;
            end
            MIE: begin
                csr_rdata[3]  = mie_q[0];
                csr_rdata[7]  = mie_q[1];
                csr_rdata[11] = mie_q[2];
            end
            MIP: begin
                csr_rdata[3]  = mip[0];
                csr_rdata[7]  = mip[1];
                csr_rdata[11] = mip[2];
            end
            MTVEC:     csr_rdata = mtvec;
            MSCRATCH:  csr_rdata = mscratch;
            MEPC:      csr_rdata = mepc;
            MCAUSE:    csr_rdata = mcause;
            MTVAL:     csr_rdata = mtval;
            MCYCLE:    csr_rdata = mcycle[`CSR_XLEN-1:0];
            MCYCLEH:   csr_rdata = mcycle[`CSR_COUNT_W-1:`CSR_XLEN];
            MINSTRET:  csr_rdata = minstret[`CSR_XLEN-1:0];
            MINSTRETH: csr_rdata = minstret[`CSR_COUNT_W-1:`CSR_XLEN];
            default:   csr_rdata = '0;
        endcase
    end

    // wdata acts as a set or clear mask for RS and RC
    always_comb begin
        case (op)
            CSR_RS:  csr_wdata = rd_data | wdata_q;
            CSR_RC:  csr_wdata = rd_data & ~wdata_q;
            default: csr_wdata = wdata_q;
        endcase
    end

    // Same modified word loads the counters
    assign load_data          = csr_wdata;
    assign mcycle_load_low    = wr_en && (addr == MCYCLE);
    assign mcycle_load_high   = wr_en && (addr == MCYCLEH);
    assign minstret_load_low  = wr_en && (addr == MINSTRET);
    assign minstret_load_high = wr_en && (addr == MINSTRETH);

    // ====================================================================
    // Register updates

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_q        <= '0;
            mtvec        <= `CSR_BOOT_ADDR;
        end else if (wr_en) begin
            case (addr)
                MSTATUS: begin
                    mstatus_mie  <= csr_wdata[3];
                    mstatus_mpie <= csr_wdata[7];
                end
                MIE:     mie_q <= {csr_wdata[11], csr_wdata[7], csr_wdata[3]};
                // Direct mode only, mode bits stay zero
                MTVEC:   mtvec <= {csr_wdata[`CSR_XLEN-1:2], 2'b00};
                default: ;
            endcase
        end else if (setup_trap) begin
            // Stack mie into mpie
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (return_from_trap) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (addr)
                MSCRATCH: mscratch <= csr_wdata;
                // IALIGN is 32
                MEPC:     mepc <= {csr_wdata[`CSR_XLEN-1:2], 2'b00};
                MCAUSE:   mcause <= csr_wdata;
                MTVAL:    mtval <= csr_wdata;
                default:  ;
            endcase
        end else if (setup_trap) begin
            mepc   <= {trapped_pc[`CSR_XLEN-1:2], 2'b00};
            mcause <= trap_cause;
            mtval  <= trap_value;
        end
    end

    // Enables out to the synchronizer
    assign glb_ie = mstatus_mie;
    assign msie   = mie_q[0];
    assign mtie   = mie_q[1];
    assign meie   = mie_q[2];

    // ====================================================================
    // Checks

    // mret and trap jumps never overlap an instruction's end
    a_done_jump: assert property (@(posedge clk) disable iff (!rstz)
        !(done && trap_jump));

endmodule

// ==== verilog/csr_irq_sync.sv ====
// Brings the asynchronous software, timer and external interrupt lines into clk
// Feeds mip to the CSR file and a level interrupt request to the core
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_irq_sync
    import csr_arch_pkg::*;
(
    input  logic       clk,
    input  logic       rstz,
    input  logic       irq_software,
    input  logic       irq_timer,
    input  logic       irq_external,
    input  logic       glb_ie,
    input  logic       msie,
    input  logic       mtie,
    input  logic       meie,
    output logic [2:0] mip,
    output logic       irq_pending
);

    irq_vec_t sync_q [`CSR_SYNC_STAGES];
    irq_vec_t irq_en;

    // Synchronizer chain, one triple per stage
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 0; i < `CSR_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= {irq_external, irq_timer, irq_software};
            for (int i = 1; i < `CSR_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Last stage is the architectural mip
    assign mip = sync_q[`CSR_SYNC_STAGES-1];

    // Per-source enables from mie, same bit order as mip
    assign irq_en      = {meie, mtie, msie};
    assign irq_pending = glb_ie && |(mip & irq_en);

endmodule

// ==== verilog/csr_params.svh ====
// Build-time constants for the machine-mode CSR unit
// Included by the packages and by every module that sizes a counter or synchronizer
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Reset value of mtvec, word aligned
`define CSR_BOOT_ADDR 32'h0000_0100
// Data word width
`define CSR_XLEN 32
// mcycle and minstret width
`define CSR_COUNT_W (2 * `CSR_XLEN)
// Flops per interrupt synchronizer
`define CSR_SYNC_STAGES 2

`endif

// ==== verilog/csr_top.sv ====
// Top level of the machine-mode CSR unit
// Connects the CSR file to the mcycle and minstret counters and the interrupt synchronizer
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_top
    import csr_arch_pkg::*;
    import csr_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rstz,
    input  csr_word_t ir,
    input  csr_word_t wr_data,
    input  csr_word_t trapped_pc,
    input  csr_word_t trap_cause,
    input  csr_word_t trap_value,
    input  logic      csr_start,
    input  logic      activate_trap,
    input  logic      return_trap,
    input  logic      instret,
    input  logic      irq_software,
    input  logic      irq_timer,
    input  logic      irq_external,
    output csr_word_t rd_data,
    output csr_word_t trap_addr,
    output reg_idx_t  csr_rd,
    output logic      csr_write,
    output logic      done,
    output logic      trap_jump,
    output logic      irq_pending
);

    csr_word_t                load_data;
    logic                     mcycle_load_low, mcycle_load_high;
    logic                     minstret_load_low, minstret_load_high;
    logic [`CSR_COUNT_W-1:0]  mcycle, minstret;
    logic                     mcycle_vld, minstret_vld;
    logic                     glb_ie, msie, mtie, meie;
    logic [2:0]               mip;

    csr_file i_file (
        .clk                (clk),
        .rstz               (rstz),
        .ir                 (ir),
        .wr_data            (wr_data),
        .csr_start          (csr_start),
        .rd_data            (rd_data),
        .csr_rd             (csr_rd),
        .csr_write          (csr_write),
        .done               (done),
        .activate_trap      (activate_trap),
        .return_trap        (return_trap),
        .trapped_pc         (trapped_pc),
        .trap_cause         (trap_cause),
        .trap_value         (trap_value),
        .trap_addr          (trap_addr),
        .trap_jump          (trap_jump),
        .load_data          (load_data),
        .mcycle_load_low    (mcycle_load_low),
        .mcycle_load_high   (mcycle_load_high),
        .minstret_load_low  (minstret_load_low),
        .minstret_load_high (minstret_load_high),
        .mcycle             (mcycle),
        .minstret           (minstret),
        .mcycle_vld         (mcycle_vld),
        .minstret_vld       (minstret_vld),
        .glb_ie             (glb_ie),
        .msie               (msie),
        .mtie               (mtie),
        .meie               (meie),
        .mip                (mip)
    );

    // Cycle counter runs every clock
    csr_counter64 i_mcycle (
        .clk       (clk),
        .rstz      (rstz),
        .incr      (1'b1),
        .load_low  (mcycle_load_low),
        .load_high (mcycle_load_high),
        .load_data (load_data),
        .count     (mcycle),
        .count_vld (mcycle_vld)
    );

    // Retired instruction count from the core's instret pulse
    csr_counter64 i_minstret (
        .clk       (clk),
        .rstz      (rstz),
        .incr      (instret),
        .load_low  (minstret_load_low),
        .load_high (minstret_load_high),
        .load_data (load_data),
        .count     (minstret),
        .count_vld (minstret_vld)
    );

    csr_irq_sync i_irq (
        .clk          (clk),
        .rstz         (rstz),
        .irq_software (irq_software),
        .irq_timer    (irq_timer),
        .irq_external (irq_external),
        .glb_ie       (glb_ie),
        .msie         (msie),
        .mtie         (mtie),
        .meie         (meie),
        .mip          (mip),
        .irq_pending  (irq_pending)
    );

endmodule
